// ==== design/dotp_macros.svh ====
// Dot-product accelerator
// Build constants

`ifndef DOTP_MACROS_SVH
`define DOTP_MACROS_SVH

//==============================
// Datapath
//==============================

// Operand and result width, all arithmetic wraps here
`define DOTP_WIDTH 16

// Operand count, four pairs into a two-level adder tree
`define DOTP_LANES 8

//==============================
// Result queue and bus
//==============================

// Queue depth, keep a power of two
`define DOTP_FIFO_DEPTH 4

// APB byte address width
`define DOTP_ADDR_W 8

`endif

// ==== design/dotp_pkg.sv ====
// Dot-product accelerator types

`include "dotp_macros.svh"

package dotp_pkg;

   //==============================
   // Register map
   //==============================

   // Byte offsets on the APB port, one word per register
   typedef enum logic [`DOTP_ADDR_W-1:0] {
      REG_OP0    = 8'h00,
      REG_OP1    = 8'h04,
      REG_OP2    = 8'h08,
      REG_OP3    = 8'h0C,
      REG_OP4    = 8'h10,
      REG_OP5    = 8'h14,
      REG_OP6    = 8'h18,
      REG_OP7    = 8'h1C,
      // Bit 0 starts a sum, bit 1 clears overflow
      REG_CTRL   = 8'h20,
      // Read only occupancy and overflow
      REG_STATUS = 8'h24,
      // Read only, pops the queue head
      REG_RESULT = 8'h28
   } reg_off_e;

   //==============================
   // Queue occupancy
   //==============================

   typedef enum logic [1:0] {
      FIFO_EMPTY   = 2'b00,
      FIFO_PARTIAL = 2'b01,
      FIFO_FULL    = 2'b10
   } fifo_state_e;

endpackage

// ==== design/mac_tree_pipeline.sv ====
// Multiply and adder-tree pipeline

`include "dotp_macros.svh"

module mac_tree_pipeline #(
   parameter int WIDTH = `DOTP_WIDTH
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] operands [`DOTP_LANES],
   input  logic             launch,
   output logic [WIDTH-1:0] sum,
   output logic             sum_valid
);

   // Input register, multiply, first add, final add
   localparam int LATENCY  = 4;
   localparam int PRODUCTS = `DOTP_LANES / 2;

   // Datapath stage registers
   logic [WIDTH-1:0]   in_r   [`DOTP_LANES];
   logic [WIDTH-1:0]   prod_r [PRODUCTS];
   logic [WIDTH-1:0]   part_r [2];
   logic [WIDTH-1:0]   sum_r;

   // Valid delay line with bit 0 at the input stage
   logic [LATENCY-1:0] valid_r;

   //==============================
   // Datapath
   //==============================

   always_ff @(posedge clk) begin
      // Stage 1 captures the operand bank every cycle
      for (int i = 0; i < `DOTP_LANES; i++) begin
         in_r[i] <= operands[i];
      end
      // Stage 2 pairs (0,1) (2,3) (4,5) (6,7)
      // Product keeps only the low WIDTH bits
      for (int i = 0; i < PRODUCTS; i++) begin
         prod_r[i] <= WIDTH'(in_r[2*i] * in_r[2*i+1]);
      end
      // Stage 3 first adder level
      for (int i = 0; i < 2; i++) begin
         part_r[i] <= prod_r[2*i] + prod_r[2*i+1];
      end
      // Stage 4 final adder wrapping at WIDTH
      sum_r <= part_r[0] + part_r[1];
   end

   assign sum = sum_r;

   //==============================
   // Valid tracking
   //==============================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_r <= '0;
      end else begin
         valid_r <= {valid_r[LATENCY-2:0], launch};
      end
   end

   assign sum_valid = valid_r[LATENCY-1];

   //==============================
   // Checks
   //==============================

   // Cycles since reset saturating at the latency
   logic [2:0] warm_cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         warm_cnt <= '0;
      end else if (warm_cnt < 3'(LATENCY)) begin
         warm_cnt <= warm_cnt + 3'd1;
      end
   end

   // Nothing can come out before the pipe has filled once
   a_quiet_after_reset: assert property (
      @(posedge clk) disable iff (rst)
      warm_cnt < 3'(LATENCY) |-> !sum_valid
   );

   // Every launch emerges exactly LATENCY clocks later
   a_fixed_latency: assert property (
      @(posedge clk) disable iff (rst)
      warm_cnt == 3'(LATENCY) |-> sum_valid == $past(launch, LATENCY)
   );

endmodule

// ==== design/dotp_apb_regs.sv ====
// APB register block

`include "dotp_macros.svh"

module dotp_apb_regs (
   input  logic                                     clk,
   input  logic                                     rst,
   // APB slave side
   input  logic                                     psel,
   input  logic                                     penable,
   input  logic                                     pwrite,
   input  logic [`DOTP_ADDR_W-1:0]                  paddr,
   input  logic [31:0]                              pwdata,
   output logic [31:0]                              prdata,
   output logic                                     pready,
   output logic                                     pslverr,
   // Pipeline side
   output logic [`DOTP_WIDTH-1:0]                   operands [`DOTP_LANES],
   output logic                                     launch,
   // Result queue side
   output logic                                     pop,
   output logic                                     clear_overflow,
   input  logic [`DOTP_WIDTH-1:0]                   head,
   input  logic [$clog2(`DOTP_FIFO_DEPTH + 1)-1:0]  count,
   input  dotp_pkg::fifo_state_e                    fifo_state,
   input  logic                                     overflow
);

   localparam int IDX_W = $clog2(`DOTP_LANES);
   localparam int CNT_W = $clog2(`DOTP_FIFO_DEPTH + 1);

   logic                   access;
   logic                   op_hit;
   logic                   ctrl_hit;
   logic                   status_hit;
   logic                   result_hit;
   logic                   unmapped;
   logic                   err;
   logic                   start_wr;
   logic [IDX_W-1:0]       op_idx;
   logic [31:0]            status_word;
   logic [31:0]            rd_data;
   logic [`DOTP_WIDTH-1:0] op_r [`DOTP_LANES];
   logic                   launch_r;

   //==============================
   // Address decode
   //==============================

   // Transfer completes in the first psel and penable cycle
   assign access = psel && penable;

   // Word index of an operand register
   assign op_idx = paddr[2 +: IDX_W];

   always_comb begin
      op_hit     = 1'b0;
      ctrl_hit   = 1'b0;
      status_hit = 1'b0;
      result_hit = 1'b0;
      unmapped   = 1'b0;
      case (dotp_pkg::reg_off_e'(paddr))
         dotp_pkg::REG_OP0, dotp_pkg::REG_OP1,
         dotp_pkg::REG_OP2, dotp_pkg::REG_OP3,
         dotp_pkg::REG_OP4, dotp_pkg::REG_OP5,
         dotp_pkg::REG_OP6, dotp_pkg::REG_OP7: op_hit = 1'b1;
         dotp_pkg::REG_CTRL:   ctrl_hit   = 1'b1;
         dotp_pkg::REG_STATUS: status_hit = 1'b1;
         dotp_pkg::REG_RESULT: result_hit = 1'b1;
         // Misaligned or out of range offsets
         default:              unmapped   = 1'b1;
      endcase
   end

   // Error on a bad offset, a read-only write or an empty result read
   assign err = unmapped
             || (pwrite && (status_hit || result_hit))
             || (!pwrite && result_hit && fifo_state == dotp_pkg::FIFO_EMPTY);

   // No wait states
   assign pready  = 1'b1;
   assign pslverr = access && err;

   //==============================
   // Operand bank and commands
   //==============================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `DOTP_LANES; i++) begin
            op_r[i] <= '0;
         end
      end else if (access && pwrite && op_hit) begin
         // Upper pwdata bits are ignored
         op_r[op_idx] <= pwdata[`DOTP_WIDTH-1:0];
      end
   end

   assign operands = op_r;

   // CTRL bit 0 starts a dot product
   assign start_wr = access && pwrite && ctrl_hit && pwdata[0];

   // Launch one cycle after the access while the bank still holds the operands
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         launch_r <= 1'b0;
      end else begin
         launch_r <= start_wr;
      end
   end

   assign launch = launch_r;

   // CTRL bit 1 acknowledges overflow
   assign clear_overflow = access && pwrite && ctrl_hit && pwdata[1];

   // Only a clean RESULT read consumes the head
   assign pop = access && !pwrite && result_hit && !err;

   //==============================
   // Read data
   //==============================

   always_comb begin
      status_word              = '0;
      status_word[CNT_W-1:0]   = count;
      status_word[5:4]         = fifo_state;
      status_word[8]           = overflow;
   end

   always_comb begin
      rd_data = '0;
      if (op_hit) begin
         rd_data = 32'(op_r[op_idx]);
      end else if (status_hit) begin
         rd_data = status_word;
      end else if (result_hit) begin
         rd_data = 32'(head);
      end
      // CTRL reads back as zero
   end

   assign prdata = (access && !pwrite) ? rd_data : '0;

   // Every APB access follows a setup cycle so no second CTRL access can relaunch at once
   a_single_launch: assert property (
      @(posedge clk) disable iff (rst)
      launch |=> !launch
   );

endmodule

// ==== design/result_fifo.sv ====
// Result queue

`include "dotp_macros.svh"

module result_fifo #(
   parameter int DEPTH = `DOTP_FIFO_DEPTH
) (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           push,
   input  logic [`DOTP_WIDTH-1:0]         push_data,
   input  logic                           pop,
   output logic [`DOTP_WIDTH-1:0]         head,
   output logic [$clog2(DEPTH + 1)-1:0]   count,
   output dotp_pkg::fifo_state_e          fifo_state,
   output logic                           overflow,
   input  logic                           clear_overflow
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [`DOTP_WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [CNT_W-1:0]       cnt_r;
   logic                   ovf_r;
   logic                   full;
   logic                   empty;
   logic                   do_push;
   logic                   do_pop;

   assign full  = (cnt_r == CNT_W'(DEPTH));
   assign empty = (cnt_r == '0);

   // A pop in the same cycle frees the slot a full push needs
   assign do_push = push && (!full || pop);
   assign do_pop  = pop && !empty;

   //==============================
   // Storage and pointers
   //==============================

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt_r  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         // Push and pop together leave the count alone
         if (do_push && !do_pop) begin
            cnt_r <= cnt_r + 1'b1;
         end else if (do_pop && !do_push) begin
            cnt_r <= cnt_r - 1'b1;
         end
      end
   end

   //==============================
   // Status
   //==============================

   // Sticky drop flag, a new drop wins over a clear
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ovf_r <= 1'b0;
      end else if (push && !do_push) begin
         ovf_r <= 1'b1;
      end else if (clear_overflow) begin
         ovf_r <= 1'b0;
      end
   end

   always_comb begin
      if (empty)     fifo_state = dotp_pkg::FIFO_EMPTY;
      else if (full) fifo_state = dotp_pkg::FIFO_FULL;
      else           fifo_state = dotp_pkg::FIFO_PARTIAL;
   end

   assign head     = mem[rd_ptr];
   assign count    = cnt_r;
   assign overflow = ovf_r;

   // Register block must gate RESULT reads on the empty status
   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (rst) !(pop && empty)
   );

   a_count_bound: assert property (
      @(posedge clk) disable iff (rst) cnt_r <= CNT_W'(DEPTH)
   );

endmodule

// ==== design/dotp_top.sv ====
// Dot-product accelerator top

`include "dotp_macros.svh"

module dotp_top (
   input  logic                    clk,
   input  logic                    rst,
   // APB slave port, pclk is clk
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  logic [`DOTP_ADDR_W-1:0] paddr,
   input  logic [31:0]             pwdata,
   output logic [31:0]             prdata,
   output logic                    pready,
   output logic                    pslverr
);

   // Register block to pipeline
   logic [`DOTP_WIDTH-1:0]                   operands [`DOTP_LANES];
   logic                                     launch;
   // Pipeline to queue
   logic [`DOTP_WIDTH-1:0]                   sum;
   logic                                     sum_valid;
   // Queue and register block
   logic                                     pop;
   logic                                     clear_overflow;
   logic [`DOTP_WIDTH-1:0]                   head;
   logic [$clog2(`DOTP_FIFO_DEPTH + 1)-1:0]  count;
   dotp_pkg::fifo_state_e                    fifo_state;
   logic                                     overflow;

   dotp_apb_regs u_regs (
      .clk            (clk),
      .rst            (rst),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .operands       (operands),
      .launch         (launch),
      .pop            (pop),
      .clear_overflow (clear_overflow),
      .head           (head),
      .count          (count),
      .fifo_state     (fifo_state),
      .overflow       (overflow)
   );

   // Four clocks from launch to sum_valid
   mac_tree_pipeline #(.WIDTH(`DOTP_WIDTH)) u_pipe (
      .clk       (clk),
      .rst       (rst),
      .operands  (operands),
      .launch    (launch),
      .sum       (sum),
      .sum_valid (sum_valid)
   );

   // Pushes without back-pressure, drops when full
   result_fifo #(.DEPTH(`DOTP_FIFO_DEPTH)) u_fifo (
      .clk            (clk),
      .rst            (rst),
      .push           (sum_valid),
      .push_data      (sum),
      .pop            (pop),
      .head           (head),
      .count          (count),
      .fifo_state     (fifo_state),
      .overflow       (overflow),
      .clear_overflow (clear_overflow)
   );

endmodule

// ==== tests/dotp_tb.sv ====
// Dot-product accelerator testbench

`include "dotp_macros.svh"

module dotp_tb;

   localparam int W     = `DOTP_WIDTH;
   localparam int LANES = `DOTP_LANES;
   localparam int DEPTH = `DOTP_FIFO_DEPTH;

   logic                    clk;
   logic                    rst;
   logic                    psel;
   logic                    penable;
   logic                    pwrite;
   logic [`DOTP_ADDR_W-1:0] paddr;
   logic [31:0]             pwdata;
   logic [31:0]             prdata;
   logic                    pready;
   logic                    pslverr;

   // Random state, expected sums in launch order, last value read
   logic [31:0]  lfsr;
   logic [W-1:0] sb [$];
   logic [W-1:0] got;
   logic [W-1:0] exp_sum;
   event         got_ev;

   dotp_top UUT (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //==============================
   // Stimulus and reference
   //==============================

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   // One full operand set, lane 0 in the low word
   function automatic logic [LANES*W-1:0] rand_set();
      logic [LANES*W-1:0] v;
      for (int i = 0; i < LANES*W; i++) begin
         v[i] = lfsr_bit();
      end
      return v;
   endfunction

   // Sum of pairwise products, every step kept to W bits
   function automatic logic [W-1:0] dot_ref(input logic [LANES*W-1:0] flat);
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W-1:0] acc;
      acc = '0;
      for (int i = 0; i < LANES/2; i++) begin
         a   = flat[2*i*W +: W];
         b   = flat[(2*i+1)*W +: W];
         acc = acc + W'(a * b);
      end
      return acc;
   endfunction

   //==============================
   // Compare tasks
   //==============================

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         abort_run($sformatf("error %s expected 0x%h actual 0x%h", name, exp, act));
      end
   endtask

   task automatic check_state(input string name, input dotp_pkg::fifo_state_e exp,
                              input dotp_pkg::fifo_state_e act);
      if (act !== exp) begin
         abort_run($sformatf("error %s expected 0x%h actual 0x%h", name, exp, act));
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("error %s expected 0x%h actual 0x%h", name, exp, act));
      end
   endtask

   // Scoreboard side, one compare per result read
   initial begin
      forever begin
         @(got_ev);
         if (sb.size() == 0) begin
            abort_run("a result was read with no sum outstanding");
         end else begin
            exp_sum = sb.pop_front();
            check_word("result", 32'(exp_sum), 32'(got));
         end
      end
   end

   //==============================
   // APB transfers
   //==============================

   // Setup cycle, access cycle, then idle
   task automatic apb_xfer(input logic wr, input logic [`DOTP_ADDR_W-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
      @(posedge clk);
      #10;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #10;
      penable = 1'b1;
      // Response is combinational, sample mid cycle
      @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      check_bit("pready", 1'b1, pready);
      @(posedge clk);
      #10;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [`DOTP_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic err);
      logic [31:0] unused;
      apb_xfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input logic [`DOTP_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic err);
      apb_xfer(1'b0, addr, 32'h0, data, err);
   endtask

   task automatic reg_write(input logic [`DOTP_ADDR_W-1:0] addr, input logic [31:0] data);
      logic err;
      apb_write(addr, data, err);
      check_bit("pslverr", 1'b0, err);
   endtask

   // Count in 2:0, state in 5:4, overflow in 8
   task automatic check_status(input int cnt, input dotp_pkg::fifo_state_e st, input logic ovf);
      logic [31:0] d;
      logic        e;
      apb_read(dotp_pkg::REG_STATUS, d, e);
      check_bit("pslverr", 1'b0, e);
      check_word("status.count", 32'(cnt), 32'(d[2:0]));
      check_state("status.fifo_state", st, dotp_pkg::fifo_state_e'(d[5:4]));
      check_bit("status.overflow", ovf, d[8]);
   endtask

   // Load the bank then start, keep=0 for a sum expected to drop
   task automatic start_sum(input logic [LANES*W-1:0] flat, input logic keep);
      for (int i = 0; i < LANES; i++) begin
         reg_write(8'(4*i), 32'(flat[i*W +: W]));
      end
      if (keep) begin
         sb.push_back(dot_ref(flat));
      end
      reg_write(dotp_pkg::REG_CTRL, 32'h1);
   endtask

   task automatic read_result();
      logic [31:0] d;
      logic        e;
      apb_read(dotp_pkg::REG_RESULT, d, e);
      check_bit("pslverr", 1'b0, e);
      got = d[W-1:0];
      -> got_ev;
   endtask

   task automatic wait_for_count(input int target);
      logic [31:0] d;
      logic        e;
      int          polls;
      polls = 0;
      d     = '0;
      while (int'(d[2:0]) < target) begin
         if (polls == 50) begin
            abort_run($sformatf("no %0d queued results after 50 status polls", target));
         end
         apb_read(dotp_pkg::REG_STATUS, d, e);
         polls++;
      end
   endtask

   task automatic wait_for_overflow();
      logic [31:0] d;
      logic        e;
      int          polls;
      polls = 0;
      d     = '0;
      while (!d[8]) begin
         if (polls == 50) begin
            abort_run("overflow never set after 50 status polls");
         end
         apb_read(dotp_pkg::REG_STATUS, d, e);
         polls++;
      end
   endtask

   //==============================
   // Scenarios
   //==============================

   initial begin
      logic [31:0] d;
      logic        e;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      lfsr    = 32'h154d07e8;
      rst     = 1'b1;
      repeat (3) @(posedge clk);
      #10;
      rst = 1'b0;

      // Idle state and operand readback
      check_bit("pslverr", 1'b0, pslverr);
      check_status(0, dotp_pkg::FIFO_EMPTY, 1'b0);
      for (int i = 0; i < LANES; i++) begin
         reg_write(8'(4*i), 32'h0000_a500 + 32'(i * 17));
      end
      for (int i = 0; i < LANES; i++) begin
         apb_read(8'(4*i), d, e);
         check_bit("pslverr", 1'b0, e);
         check_word("operand", 32'h0000_a500 + 32'(i * 17), d);
      end

      // All ones, every product wraps to 1
      start_sum('1, 1'b1);
      wait_for_count(1);
      read_result();
      // Single sums with random operands
      for (int n = 0; n < 20; n++) begin
         start_sum(rand_set(), 1'b1);
         wait_for_count(1);
         read_result();
      end

      // Fill the queue, then drain in launch order
      for (int n = 0; n < DEPTH; n++) begin
         start_sum(rand_set(), 1'b1);
      end
      wait_for_count(DEPTH);
      check_status(DEPTH, dotp_pkg::FIFO_FULL, 1'b0);
      read_result();
      check_status(DEPTH - 1, dotp_pkg::FIFO_PARTIAL, 1'b0);
      for (int n = 1; n < DEPTH; n++) begin
         read_result();
      end
      check_status(0, dotp_pkg::FIFO_EMPTY, 1'b0);

      // One extra sum into a full queue is dropped
      for (int n = 0; n < DEPTH; n++) begin
         start_sum(rand_set(), 1'b1);
      end
      start_sum(rand_set(), 1'b0);
      wait_for_overflow();
      check_status(DEPTH, dotp_pkg::FIFO_FULL, 1'b1);
      for (int n = 0; n < DEPTH; n++) begin
         read_result();
      end
      check_status(0, dotp_pkg::FIFO_EMPTY, 1'b1);
      reg_write(dotp_pkg::REG_CTRL, 32'h2);
      check_status(0, dotp_pkg::FIFO_EMPTY, 1'b0);

      // Error responses leave the queue alone
      start_sum(rand_set(), 1'b1);
      wait_for_count(1);
      apb_read(8'h2c, d, e);
      check_bit("pslverr", 1'b1, e);
      apb_read(8'h02, d, e);
      check_bit("pslverr", 1'b1, e);
      apb_write(dotp_pkg::REG_STATUS, 32'h1ff, e);
      check_bit("pslverr", 1'b1, e);
      check_status(1, dotp_pkg::FIFO_PARTIAL, 1'b0);
      read_result();
      apb_read(dotp_pkg::REG_RESULT, d, e);
      check_bit("pslverr", 1'b1, e);
      check_status(0, dotp_pkg::FIFO_EMPTY, 1'b0);

      if (sb.size() != 0) begin
         abort_run("some expected sums were never read back");
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

// ==== tb.f ====
+incdir+design
design/dotp_pkg.sv
design/mac_tree_pipeline.sv
design/dotp_apb_regs.sv
design/result_fifo.sv
design/dotp_top.sv
tests/dotp_tb.sv

// ==== Bender.yml ====
package:
  name: dotp

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/dotp_pkg.sv
      - design/mac_tree_pipeline.sv
      - design/dotp_apb_regs.sv
      - design/result_fifo.sv
      - design/dotp_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - tests/dotp_tb.sv
